//--- main_settings.svh
// ********************
// Main CPU address map constants and memory sizes
// ********************
`ifndef MAIN_SETTINGS_SVH
`define MAIN_SETTINGS_SVH

`define MAIN_ROM_BASE   16'h6000    // ROM window start
`define MAIN_WRAM_AW    12          // 4 KB work RAM
`define MAIN_VEC_AW     4           // 16 vector bytes

// Address prefixes
`define MAIN_OBJ_PFX    5'b01000    // 4000-47FF on addr[15:11]
`define MAIN_VRAM_PFX   5'b01001    // 4800-4FFF on addr[15:11]
`define MAIN_WRAM_PFX   4'h5        // 5000-5FFF on addr[15:12]
`define MAIN_IORD_PFX   7'h18       // 3000-31FF on addr[15:9]
`define MAIN_IOWR_PFX   7'h40       // 8000-81FF on addr[15:9]
`define MAIN_VEC_PFX    12'hfff     // FFF0-FFFF on addr[15:4]

`endif

//--- main_pkg.sv
// ********************
// Shared bus, select, cabinet and control types
// ********************
package main_pkg;

    // CPU side of the bus, sampled by the glue
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic        vma;     // Valid memory access
        logic [7:0]  dout;    // CPU write data
        logic        cen;     // Bus clock enable
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic vram;
        logic objram;
        logic wram;
        logic vec_rd;       // Vector fetch at FFF0-FFFD
        logic vec_io;       // Vector RAM through the I/O window
        logic dip1;
        logic dip3;
        logic cabinet_io;
        logic snd;
        logic oreg;
        logic bus_error;
    } cs_t;

    typedef struct packed {
        logic [1:0]  start;
        logic [1:0]  coin;
        logic        service;
        logic [5:0]  joy1;
        logic [5:0]  joy2;
        logic [23:0] dipsw;   // Three DIP banks
    } cabinet_t;

    // Outputs of the 259 latch
    typedef struct packed {
        logic flip;
        logic snd_on;
        logic mute;
        logic firq_en;
        logic irq_en;
    } ctrl_t;

endpackage

//--- main_decode.sv
// ********************
// Main CPU address decoder
// Chip selects and bus error flag
// ********************
`timescale 1ns/1ps
`include "main_settings.svh"

module main_decode (
    input  main_pkg::cpu_bus_t bus,
    output main_pkg::cs_t      cs
);
    logic io_rd;
    logic io_wr;
    logic vec_area;

    always_comb begin
        // FFFE/FFFF reset vector still comes from ROM
        vec_area = bus.addr[15:4] == `MAIN_VEC_PFX && !(&bus.addr[3:1]);
        io_rd    = bus.vma && bus.rnw && bus.addr[15:9] == `MAIN_IORD_PFX;
        io_wr    = bus.vma && !bus.rnw && bus.addr[15:9] == `MAIN_IOWR_PFX;

        cs.objram = bus.vma && bus.addr[15:11] == `MAIN_OBJ_PFX;
        cs.vram   = bus.vma && bus.addr[15:11] == `MAIN_VRAM_PFX;
        cs.wram   = bus.vma && bus.addr[15:12] == `MAIN_WRAM_PFX;
        cs.rom    = bus.vma && bus.rnw && bus.addr >= `MAIN_ROM_BASE && !vec_area;
        cs.vec_rd = bus.vma && bus.rnw && vec_area;

        // I/O page split by addr[8:7]
        cs.dip1       = io_rd && bus.addr[8:7] == 2'd0;
        cs.cabinet_io = io_rd && bus.addr[8:7] == 2'd1;
        cs.dip3       = io_rd && bus.addr[8:7] == 2'd2;
        cs.vec_io     = (io_rd || io_wr) && bus.addr[8:7] == 2'd3;
        cs.oreg       = io_wr && bus.addr[8:7] == 2'd1;
        cs.snd        = io_wr && bus.addr[8:7] == 2'd2;

        cs.bus_error = bus.vma && !(
            cs.rom        ||
            cs.vram       ||
            cs.objram     ||
            cs.wram       ||
            cs.vec_rd     ||
            cs.vec_io     ||
            cs.dip1       ||
            cs.dip3       ||
            cs.cabinet_io ||
            cs.snd        ||
            cs.oreg
        );  // Nothing claimed the access
    end

endmodule

//--- main_ram.sv
// ********************
// Byte RAM with registered read
// ********************
`timescale 1ns/1ps

module main_ram #(
    parameter int AW = 12
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  logic [7:0]    din,
    output logic [7:0]    dout
);
    logic [7:0] mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];    // Old data on a write cycle
    end

endmodule

//--- main_read_mux.sv
// ********************
// CPU read data path
// Cabinet byte formatting and registered read mux
// ********************
`timescale 1ns/1ps

module main_read_mux (
    input  logic               clk,
    input  main_pkg::cpu_bus_t bus,
    input  main_pkg::cs_t      cs,
    input  main_pkg::cabinet_t cab,
    input  logic [7:0]         rom_data,
    input  logic [7:0]         vram_dout,
    input  logic [7:0]         obj_dout,
    input  logic [7:0]         wram_dout,
    input  logic [7:0]         vec_dout,
    output logic [7:0]         cpu_din
);
    logic [7:0] cab_byte;

    // First stage, same latency as the RAMs
    always_ff @(posedge clk) begin
        case (bus.addr[1:0])
            2'd0: cab_byte <= {3'b111, cab.start, cab.service, cab.coin};
            2'd1: cab_byte <= {2'b11, cab.joy1[5:4], cab.joy1[2], cab.joy1[3],
                               cab.joy1[0], cab.joy1[1]};
            2'd2: cab_byte <= {2'b11, cab.joy2[5:4], cab.joy2[2], cab.joy2[3],
                               cab.joy2[0], cab.joy2[1]};
            default: cab_byte <= cab.dipsw[7:0];   // DIP2 shares the cabinet page
        endcase
    end

    // Second stage, fixed priority
    always_ff @(posedge clk) begin
        if (cs.rom) begin
            cpu_din <= rom_data;
        end else if (cs.vram) begin
            cpu_din <= vram_dout;
        end else if (cs.objram) begin
            cpu_din <= obj_dout;
        end else if (cs.wram) begin
            cpu_din <= wram_dout;
        end else if (cs.dip1) begin
            cpu_din <= cab.dipsw[15:8];
        end else if (cs.dip3) begin
            cpu_din <= cab.dipsw[23:16];
        end else if (cs.cabinet_io) begin
            cpu_din <= cab_byte;
        end else if (cs.vec_rd || cs.vec_io) begin
            cpu_din <= vec_dout;
        end else begin
            cpu_din <= 8'hff;   // Open bus
        end
    end

endmodule

//--- main_latch.sv
// ********************
// 74LS259 style output latch and sound command latch
// ********************
`timescale 1ns/1ps

module main_latch (
    input  logic               clk,
    input  logic               rst,
    input  main_pkg::cpu_bus_t bus,
    input  main_pkg::cs_t      cs,
    output main_pkg::ctrl_t    ctrl,
    output logic [7:0]         snd_latch
);
    logic wr_stb;

    assign wr_stb = bus.cen && !bus.rnw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl      <= '0;
            snd_latch <= 8'd0;
        end else if (wr_stb) begin
            if (cs.snd) begin
                snd_latch <= bus.dout;
            end
            if (cs.oreg) begin
                // Data bit 0 goes to the addressed output
                case (bus.addr[2:0])
                    3'd0: ctrl.flip    <= bus.dout[0];
                    3'd1: ctrl.snd_on  <= bus.dout[0];
                    3'd2: ctrl.mute    <= bus.dout[0];
                    3'd6: ctrl.firq_en <= bus.dout[0];
                    3'd7: ctrl.irq_en  <= bus.dout[0];
                    default: ;    // Coin counters and a spare pin
                endcase
            end
        end
    end

endmodule

//--- main_irq.sv
// ********************
// Vertical blank interrupts
// IRQ every frame and FIRQ every second frame
// ********************
`timescale 1ns/1ps

module main_irq (
    input  logic            clk,
    input  logic            rst,
    input  logic            lvbl,
    input  logic            dip_pause,
    input  main_pkg::ctrl_t ctrl,
    output logic            irq_n,
    output logic            firq_n
);
    logic lvbl_l;
    logic vb_fall;
    logic odd;      // Frame parity

    assign vb_fall = lvbl_l && !lvbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            odd    <= 1'b0;
            irq_n  <= 1'b1;
            firq_n <= 1'b1;
        end else begin
            lvbl_l <= lvbl;

            // IRQ flip-flop, held clear by irq_en low
            if (!ctrl.irq_en) begin
                irq_n <= 1'b1;
            end else if (vb_fall && dip_pause) begin
                irq_n <= 1'b0;
            end

            if (vb_fall) begin
                odd <= !odd;
                if (!odd) begin
                    firq_n <= 1'b0;     // First frame of each pair
                end
            end
            if (!ctrl.firq_en || !dip_pause) begin
                firq_n <= 1'b1;
            end
        end
    end

endmodule

//--- main_board.sv
// ********************
// Main CPU glue top level
// Decoding, RAMs, read mux, latches and interrupts
// ********************
`timescale 1ns/1ps
`include "main_settings.svh"

module main_board (
    input  logic               clk,
    input  logic               rst,
    input  main_pkg::cpu_bus_t bus,
    input  main_pkg::cabinet_t cab,
    input  logic               lvbl,
    input  logic               dip_pause,
    input  logic               rom_ok,
    input  logic [7:0]         rom_data,
    input  logic [7:0]         vram_dout,
    input  logic [7:0]         obj_dout,
    output logic [15:0]        rom_addr,
    output logic [10:0]        bus_addr,
    output logic               rom_cs,
    output logic               vram_cs,
    output logic               objram_cs,
    output logic               bus_error,
    output logic [7:0]         cpu_din,
    output logic [7:0]         snd_latch,
    output main_pkg::ctrl_t    ctrl,
    output logic               irq_n,
    output logic               firq_n,
    output logic               rom_wait
);
    import main_pkg::*;

    cs_t        cs;
    logic       wr_stb;
    logic       wram_we;
    logic       vec_we;
    logic [7:0] wram_dout;
    logic [7:0] vec_dout;

    assign rom_addr  = bus.addr - `MAIN_ROM_BASE;
    assign bus_addr  = bus.addr[10:0];     // Shared with video and object RAM
    assign rom_cs    = cs.rom;
    assign vram_cs   = cs.vram;
    assign objram_cs = cs.objram;
    assign bus_error = cs.bus_error;
    assign rom_wait  = cs.rom && !rom_ok;

    assign wr_stb  = bus.cen && bus.vma && !bus.rnw;
    assign wram_we = wr_stb && cs.wram;
    assign vec_we  = wr_stb && cs.vec_io;

    main_decode u_decode (.bus(bus), .cs(cs));

    main_ram #(.AW(`MAIN_WRAM_AW)) u_wram (
        .clk  (clk),
        .we   (wram_we),
        .addr (bus.addr[`MAIN_WRAM_AW-1:0]),
        .din  (bus.dout),
        .dout (wram_dout)
    );

    // Fetches and I/O writes both index with addr[3:0]
    main_ram #(.AW(`MAIN_VEC_AW)) u_vec (
        .clk  (clk),
        .we   (vec_we),
        .addr (bus.addr[`MAIN_VEC_AW-1:0]),
        .din  (bus.dout),
        .dout (vec_dout)
    );

    main_read_mux u_mux (
        .clk       (clk),
        .bus       (bus),
        .cs        (cs),
        .cab       (cab),
        .rom_data  (rom_data),
        .vram_dout (vram_dout),
        .obj_dout  (obj_dout),
        .wram_dout (wram_dout),
        .vec_dout  (vec_dout),
        .cpu_din   (cpu_din)
    );

    main_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .cs        (cs),
        .ctrl      (ctrl),
        .snd_latch (snd_latch)
    );

    main_irq u_irq (
        .clk       (clk),
        .rst       (rst),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .ctrl      (ctrl),
        .irq_n     (irq_n),
        .firq_n    (firq_n)
    );

endmodule

//--- tb_main_board.sv
// ********************
// Testbench for the main CPU glue
// Table of bus accesses and frames against expected values
// ********************
`timescale 1ns/1ps

module tb_main_board;
    import main_pkg::*;

    localparam logic [1:0] OP_WR    = 2'd0;
    localparam logic [1:0] OP_RD    = 2'd1;
    localparam logic [1:0] OP_FRAME = 2'd2;

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;    // Write data, port data on reads, dip_pause on frames
        logic [15:0] exp;     // Read byte, or {irq_n, firq_n, ctrl, snd_latch}
    } row_t;

    logic        clk, rst, lvbl, dip_pause, rom_ok;
    cpu_bus_t    bus;
    cabinet_t    cab;
    logic [7:0]  rom_data, vram_dout, obj_dout;
    logic [15:0] rom_addr;
    logic [10:0] bus_addr;
    logic        rom_cs, vram_cs, objram_cs, bus_error;
    logic [7:0]  cpu_din, snd_latch;
    ctrl_t       ctrl;
    logic        irq_n, firq_n, rom_wait;

    // Reference state, advanced while the table is built
    ctrl_t       m_ctrl;
    logic [7:0]  m_snd;
    logic        m_irq_n, m_firq_n, m_odd, m_pause;

    row_t        rows [$];
    logic [31:0] seed = 32'hca6;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;

    main_board i_dut (
        .clk(clk), .rst(rst), .bus(bus), .cab(cab),
        .lvbl(lvbl), .dip_pause(dip_pause), .rom_ok(rom_ok),
        .rom_data(rom_data), .vram_dout(vram_dout), .obj_dout(obj_dout),
        .rom_addr(rom_addr), .bus_addr(bus_addr),
        .rom_cs(rom_cs), .vram_cs(vram_cs), .objram_cs(objram_cs), .bus_error(bus_error),
        .cpu_din(cpu_din), .snd_latch(snd_latch), .ctrl(ctrl),
        .irq_n(irq_n), .firq_n(firq_n), .rom_wait(rom_wait)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run timed out after %0d cycles", limit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [15:0] status_word();
        return {1'b0, m_irq_n, m_firq_n, m_ctrl, m_snd};
    endfunction

    // Joystick byte, up/down and left/right pairs swapped
    function automatic logic [7:0] joy_byte(input logic [5:0] j);
        return {2'b11, j[5:4], j[2], j[3], j[0], j[1]};
    endfunction

    function automatic logic [7:0] cab_expect(input logic [1:0] sel);
        case (sel)
            2'd0:    return {3'b111, cab.start, cab.service, cab.coin};
            2'd1:    return joy_byte(cab.joy1);
            2'd2:    return joy_byte(cab.joy2);
            default: return cab.dipsw[7:0];
        endcase
    endfunction

    task automatic add_read(input logic [15:0] addr, input logic [7:0] port,
                            input logic [7:0] exp);
        rows.push_back({OP_RD, addr, port, 8'h00, exp});
    endtask

    task automatic add_write(input logic [15:0] addr, input logic [7:0] data);
        if (addr >= 16'h8080 && addr < 16'h8100) begin
            case (addr[2:0])
                3'd0: m_ctrl.flip    = data[0];
                3'd1: m_ctrl.snd_on  = data[0];
                3'd2: m_ctrl.mute    = data[0];
                3'd6: m_ctrl.firq_en = data[0];
                3'd7: m_ctrl.irq_en  = data[0];
                default: ;
            endcase
        end else if (addr >= 16'h8100 && addr < 16'h8180) begin
            m_snd = data;
        end
        if (!m_ctrl.irq_en) begin
            m_irq_n = 1'b1;
        end
        if (!m_ctrl.firq_en || !m_pause) begin
            m_firq_n = 1'b1;
        end
        rows.push_back({OP_WR, addr, data, status_word()});
    endtask

    task automatic add_latch(input logic [2:0] sel, input logic v);
        logic [31:0] r;
        r = next_rand();
        add_write(16'h8080 + {13'd0, sel}, {r[31:25], v});   // Upper bits are don't care
    endtask

    task automatic add_frame(input logic pause);
        m_pause = pause;
        if (m_ctrl.irq_en && pause) begin
            m_irq_n = 1'b0;
        end
        if (!m_odd) begin
            m_firq_n = 1'b0;
        end
        m_odd = !m_odd;
        if (!m_ctrl.firq_en || !pause) begin
            m_firq_n = 1'b1;
        end
        rows.push_back({OP_FRAME, 16'h0000, {7'd0, pause}, status_word()});
    endtask

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (exp !== got) begin
            errors++;
            $display("mismatch %s exp %h got %h", name, exp, got);
            $display(">>> FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_status(input logic [15:0] exp);
        check("irq_n", {15'd0, exp[14]}, {15'd0, irq_n});
        check("firq_n", {15'd0, exp[13]}, {15'd0, firq_n});
        check("ctrl", {11'd0, exp[12:8]}, {11'd0, ctrl});
        check("snd_latch", {8'd0, exp[7:0]}, {8'd0, snd_latch});
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #10;    // Drive and sample point
    endtask

    task automatic apply_row(input row_t r);
        logic exp_rom, exp_vram, exp_obj, exp_err;
        exp_rom  = r.addr >= 16'h6000 && !(r.addr >= 16'hfff0 && r.addr <= 16'hfffd);
        exp_vram = r.addr >= 16'h4800 && r.addr < 16'h5000;
        exp_obj  = r.addr >= 16'h4000 && r.addr < 16'h4800;
        exp_err  = r.addr < 16'h3000 || (r.addr >= 16'h3200 && r.addr < 16'h4000);
        if (r.op == OP_FRAME) begin
            dip_pause = r.data[0];
            lvbl = 1'b1;
            wait_clocks(2);
            lvbl = 1'b0;    // Start of vertical blank
            wait_clocks(3);
            check_status(r.exp);
            lvbl = 1'b1;
            wait_clocks(1);
        end else begin
            if (r.op == OP_RD) begin
                rom_ok = !rom_ok;   // ROM stalls on every second read
            end
            bus.addr = r.addr;
            bus.rnw  = r.op == OP_RD;
            bus.vma  = 1'b1;
            bus.cen  = 1'b1;
            bus.dout = (r.op == OP_WR) ? r.data : 8'h00;
            // Only the addressed port carries the row data
            rom_data  = exp_rom ? r.data : ~r.data;
            vram_dout = exp_vram ? r.data : ~r.data;
            obj_dout  = exp_obj ? r.data : ~r.data;
            wait_clocks(4);
            if (r.op == OP_RD) begin
                check("cpu_din", {8'd0, r.exp[7:0]}, {8'd0, cpu_din});
                check("rom_cs", {15'd0, exp_rom}, {15'd0, rom_cs});
                check("vram_cs", {15'd0, exp_vram}, {15'd0, vram_cs});
                check("objram_cs", {15'd0, exp_obj}, {15'd0, objram_cs});
                check("bus_error", {15'd0, exp_err}, {15'd0, bus_error});
                check("bus_addr", {5'd0, r.addr[10:0]}, {5'd0, bus_addr});
                check("rom_wait", {15'd0, exp_rom && !rom_ok}, {15'd0, rom_wait});
                if (exp_rom) begin
                    check("rom_addr", r.addr - 16'h6000, rom_addr);
                end
            end else begin
                check_status(r.exp);
            end
            bus.vma = 1'b0;
            bus.cen = 1'b0;
            bus.rnw = 1'b1;
            wait_clocks(1);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] wr_addr [4];
        logic [7:0]  wr_data [4];
        logic [7:0]  vec_data [4];

        rst = 1'b1;
        lvbl = 1'b1;
        dip_pause = 1'b1;
        rom_ok = 1'b1;
        bus = '0;
        bus.rnw = 1'b1;
        rom_data = 8'h00;
        vram_dout = 8'h00;
        obj_dout = 8'h00;
        r = next_rand();
        cab.start = r[31:30];
        cab.coin = r[29:28];
        cab.service = r[27];
        cab.joy1 = r[26:21];
        cab.joy2 = r[20:15];
        r = next_rand();
        cab.dipsw = r[31:8];
        m_ctrl = '0;
        m_snd = 8'h00;
        m_irq_n = 1'b1;
        m_firq_n = 1'b1;
        m_odd = 1'b0;
        m_pause = 1'b1;

        // ROM window and an unmapped page
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            add_read(16'h6000 + {2'b00, r[29:16]}, r[15:8], r[15:8]);
        end
        add_read(16'hfffe, r[23:16], r[23:16]);   // Reset vector stays in ROM
        add_read(16'h2000, r[31:24], 8'hff);

        // Work RAM, one 1 KB slice per entry
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            wr_addr[i] = {4'h5, i[1:0], r[29:20]};
            wr_data[i] = r[15:8];
            add_write(wr_addr[i], wr_data[i]);
        end
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            add_read(wr_addr[i], r[15:8], wr_data[i]);
        end
        r = next_rand();
        add_read({5'b01001, r[26:16]}, r[15:8], r[15:8]);
        r = next_rand();
        add_read({5'b01000, r[26:16]}, r[15:8], r[15:8]);

        // Vector RAM, written through I/O and read from both windows
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            vec_data[i] = r[23:16];
            add_write({12'h818, i[1:0], 2'b01}, vec_data[i]);
        end
        for (int i = 0; i < 4; i++) begin
            add_read({12'hfff, i[1:0], 2'b01}, 8'h00, vec_data[i]);
            add_read({12'h318, i[1:0], 2'b01}, 8'h00, vec_data[i]);
        end

        for (int i = 0; i < 4; i++) begin
            add_read(16'h3080 + {14'd0, i[1:0]}, 8'h00, cab_expect(i[1:0]));
        end
        add_read(16'h3000, 8'h00, cab.dipsw[15:8]);
        add_read(16'h3100, 8'h00, cab.dipsw[23:16]);

        add_latch(3'd0, 1'b1);
        add_latch(3'd1, 1'b1);
        add_latch(3'd2, 1'b1);
        add_latch(3'd6, 1'b1);
        add_latch(3'd7, 1'b1);
        add_latch(3'd3, 1'b1);    // Unused outputs
        add_latch(3'd4, 1'b1);
        add_latch(3'd5, 1'b1);
        add_latch(3'd0, 1'b0);
        add_latch(3'd2, 1'b0);
        r = next_rand();
        add_write(16'h8100, r[23:16]);

        // Five vertical blanks, the second one paused
        add_frame(1'b1);
        add_latch(3'd7, 1'b0);
        add_latch(3'd7, 1'b1);
        add_frame(1'b0);
        add_frame(1'b1);
        add_latch(3'd7, 1'b0);
        add_latch(3'd7, 1'b1);
        add_latch(3'd6, 1'b0);
        add_latch(3'd6, 1'b1);
        add_frame(1'b1);
        add_latch(3'd7, 1'b0);
        add_latch(3'd7, 1'b1);
        add_frame(1'b1);

        limit = rows.size() * 8 + 200;
        wait_clocks(16);
        rst = 1'b0;
        foreach (rows[k]) begin
            apply_row(rows[k]);
        end

        if (errors == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- src.f
+incdir+.
main_pkg.sv
main_decode.sv
main_ram.sv
main_read_mux.sv
main_latch.sv
main_irq.sv
main_board.sv
tb_main_board.sv

//--- Makefile
# Verilator simulation of the main CPU glue
VERILATOR ?= verilator
TOP       ?= tb_main_board
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
